/* rtl/spim_pkg.sv */
//////////////////////////////
// spim package
// word and burst widths, shared types and the
// burst controller state encoding
//////////////////////////////

package spim_pkg;

	parameter int WORD_W    = 32;	// serial word, msb first
	parameter int BURST_W   = 14;	// burst length and word index width
	parameter int BIT_CNT_W = 5;	// bit position inside a word

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [BURST_W-1:0] burst_t;

	//////////////////////////////
	// controller states
	//////////////////////////////
	typedef enum logic [2:0] {
		ST_IDLE,	// waiting for a rising edge on s_transvld
		ST_CMD,		// first word being fetched, frame not yet open
		ST_SHIFT,	// frame open, words streaming
		ST_LAST,	// frame closed, waiting for the last rx word
		ST_END		// wind down before the done pulse
	} spim_state_e;

endpackage

/* rtl/spim_lane_if.sv */
//////////////////////////////
// spim lane interface
// framing and word traffic between the burst
// controller and the two shifters
//////////////////////////////

interface spim_lane_if #(
	parameter int WORD_W = spim_pkg::WORD_W
) ();

	logic              frame_on;	// selected slave active
	logic              word_load;	// next falling edge starts a new word
	logic [WORD_W-1:0] tx_word;	// word to be sent
	logic [WORD_W-1:0] rx_word;	// last assembled word
	logic              rx_valid;	// one cycle per received word

	modport ctrl (
		output frame_on,
		output word_load,
		output tx_word,
		input  rx_word,
		input  rx_valid
	);

	modport tx (
		input frame_on,
		input word_load,
		input tx_word
	);

	modport rx (
		input  frame_on,
		output rx_word,
		output rx_valid
	);

endinterface

/* rtl/spim_tx_shift.sv */
//////////////////////////////
// spim transmit shifter
// launches words on mosi at falling edges,
// msb first, zero fill behind the word
//////////////////////////////

module spim_tx_shift #(
	parameter int WORD_W = spim_pkg::WORD_W
) (
	input  logic       sclk_in,
	input  logic       rst_n,
	spim_lane_if.tx    lane,
	output logic       mosi
);

	// bits of the current word still waiting to go out
	logic [WORD_W-1:0] stage_q;

	//////////////////////////////
	// falling edge shift path
	//////////////////////////////
	always_ff @(negedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			stage_q <= '0;
			mosi    <= 1'b0;
		end
		else if (!lane.frame_on) begin	// idle line between bursts
			stage_q <= '0;
			mosi    <= 1'b0;
		end
		else if (lane.word_load) begin
			// msb goes straight out, rest is staged
			mosi    <= lane.tx_word[WORD_W-1];
			stage_q <= {lane.tx_word[WORD_W-2:0], 1'b0};
		end
		else begin
			mosi    <= stage_q[WORD_W-1];
			stage_q <= {stage_q[WORD_W-2:0], 1'b0};	// zero fill
		end
	end

endmodule

/* rtl/spim_rx_shift.sv */
//////////////////////////////
// spim receive shifter
// samples miso on rising edges and hands
// each complete word to the controller
//////////////////////////////

module spim_rx_shift #(
	parameter int WORD_W = spim_pkg::WORD_W
) (
	input  logic    sclk_in,
	input  logic    rst_n,
	input  logic    miso,
	spim_lane_if.rx lane
);

	import spim_pkg::*;

	localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(WORD_W - 1);

	logic [BIT_CNT_W-1:0] cnt_q;	// bits taken in the current word
	logic [WORD_W-1:0]    shift_q;
	logic                 word_done;

	assign word_done = lane.frame_on & (cnt_q == BIT_LAST);

	//////////////////////////////
	// bit counter and word strobe
	//////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q         <= '0;
			lane.rx_valid <= 1'b0;
		end
		else begin
			lane.rx_valid <= word_done;
			if (!lane.frame_on)
				cnt_q <= '0;	// realign on every frame
			else
				cnt_q <= cnt_q + 1'b1;	// wraps at the word boundary
		end
	end

	// data path, msb arrives first
	always_ff @(posedge sclk_in) begin
		if (lane.frame_on)
			shift_q <= {shift_q[WORD_W-2:0], miso};
		if (word_done)
			lane.rx_word <= {shift_q[WORD_W-2:0], miso};	// include the bit sampled now
	end

endmodule

/* rtl/spim_burst_ctrl.sv */
//////////////////////////////
// spim burst controller
// sequences a burst of words, fetches tx data,
// drives the slave selects and the strobes
//////////////////////////////

module spim_burst_ctrl #(
	parameter int WORD_W  = spim_pkg::WORD_W,
	parameter int BURST_W = spim_pkg::BURST_W
) (
	input  logic             sclk_in,
	input  logic             rst_n,
	input  spim_pkg::word_t  tx_rdata,
	input  spim_pkg::burst_t spim_brstlen,
	input  logic             s_transvld,
	input  logic             spim_rdnwr,
	input  logic [1:0]       spim_sselect,
	spim_lane_if.ctrl        lane,
	output logic             ss_n_0,
	output logic             ss_n_1,
	output logic             ss_n_2,
	output logic             ss_n_3,
	output logic             spi_read,
	output logic             spi_write,
	output logic             cmd_is_read,
	output logic             cmd_is_write,
	output spim_pkg::burst_t tx_addr,
	output spim_pkg::burst_t rx_addr,
	output spim_pkg::word_t  rx_wdata,
	output logic             stransvld_up
);

	import spim_pkg::*;

	localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(WORD_W - 1);
	localparam logic [BIT_CNT_W-1:0] BIT_FETCH = BIT_CNT_W'(WORD_W - 4);	// 4 bits before the end

	spim_state_e          state;
	logic                 s_transvld_q;
	logic                 start;
	logic                 busy;
	logic                 dir_rd;		// latched spim_rdnwr
	logic [1:0]           sel_q;		// latched slave number
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BURST_W-1:0]   words_left;	// words still to start after the current one
	logic                 more_words;
	logic                 fetch_q;		// tx_rdata is valid this cycle
	logic [3:0]           ss_dec;

	assign start      = s_transvld & ~s_transvld_q & (state == ST_IDLE);
	assign busy       = (state != ST_IDLE);
	assign more_words = (words_left != '0);

	//////////////////////////////
	// strobes and levels
	//////////////////////////////
	assign spi_read = start | ((state == ST_SHIFT) & (bit_cnt == BIT_FETCH) & more_words);

	// direction shows up together with the first fetch
	assign cmd_is_read  = busy ? dir_rd : (start & spim_rdnwr);
	assign cmd_is_write = busy ? ~dir_rd : (start & ~spim_rdnwr);

	assign spi_write = lane.rx_valid & busy & dir_rd;
	assign rx_wdata  = lane.rx_word;

	//////////////////////////////
	// burst sequencer
	//////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			state          <= ST_IDLE;
			s_transvld_q   <= 1'b0;
			dir_rd         <= 1'b0;
			sel_q          <= 2'd0;
			words_left     <= '0;
			bit_cnt        <= '0;
			lane.frame_on  <= 1'b0;
			lane.word_load <= 1'b0;
			stransvld_up   <= 1'b0;
		end
		else begin
			s_transvld_q   <= s_transvld;
			lane.word_load <= 1'b0;
			stransvld_up   <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state      <= ST_CMD;
						dir_rd     <= spim_rdnwr;
						sel_q      <= spim_sselect;
						words_left <= spim_brstlen - 1'b1;	// word 0 is already on its way
					end
				end
				ST_CMD: begin	// word 0 captured on the falling edge of this cycle
					state          <= ST_SHIFT;
					lane.frame_on  <= 1'b1;
					lane.word_load <= 1'b1;
					bit_cnt        <= '0;
				end
				ST_SHIFT: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_LAST) begin
						if (more_words) begin	// back to back, no gap
							lane.word_load <= 1'b1;
							words_left     <= words_left - 1'b1;
						end
						else begin
							lane.frame_on <= 1'b0;
							state         <= ST_LAST;
						end
					end
				end
				ST_LAST: begin
					if (lane.rx_valid) begin	// last word is in
						state   <= ST_END;
						bit_cnt <= '0;
					end
				end
				ST_END: begin
					// two cycles of wind down, reusing the bit counter
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt[0]) begin
						state        <= ST_IDLE;
						stransvld_up <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// word indices
	//////////////////////////////
	always_ff @(posedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			fetch_q <= 1'b0;
			tx_addr <= '0;
			rx_addr <= '0;
		end
		else begin
			fetch_q <= spi_read;
			if (state == ST_END) begin	// ready for the next burst
				tx_addr <= '0;
				rx_addr <= '0;
			end
			else begin
				if (spi_read)
					tx_addr <= tx_addr + 1'b1;
				if (lane.rx_valid)
					rx_addr <= rx_addr + 1'b1;	// counted on writes too
			end
		end
	end

	// fetched word, held until the tx shifter loads it
	always_ff @(negedge sclk_in) begin
		if (fetch_q)
			lane.tx_word <= tx_rdata;
	end

	//////////////////////////////
	// slave select
	//////////////////////////////
	always_comb begin
		ss_dec = 4'b1111;
		if (lane.frame_on)
			ss_dec[sel_q] = 1'b0;
	end

	always_ff @(negedge sclk_in or negedge rst_n) begin
		if (!rst_n) begin
			ss_n_0 <= 1'b1;
			ss_n_1 <= 1'b1;
			ss_n_2 <= 1'b1;
			ss_n_3 <= 1'b1;
		end
		else begin
			ss_n_0 <= ss_dec[0];
			ss_n_1 <= ss_dec[1];
			ss_n_2 <= ss_dec[2];
			ss_n_3 <= ss_dec[3];
		end
	end

endmodule

/* rtl/spim_top.sv */
//////////////////////////////
// spim top
// spi master burst engine in mode 0
//////////////////////////////

module spim_top #(
	parameter int WORD_W  = spim_pkg::WORD_W,
	parameter int BURST_W = spim_pkg::BURST_W
) (
	input  logic             sclk_in,
	input  logic             rst_n,
	input  logic             miso,
	input  spim_pkg::word_t  tx_rdata,
	input  spim_pkg::burst_t spim_brstlen,
	input  logic             s_transvld,
	input  logic             spim_rdnwr,
	input  logic [1:0]       spim_sselect,
	output logic             ss_n_0,
	output logic             ss_n_1,
	output logic             ss_n_2,
	output logic             ss_n_3,
	output logic             sclk,
	output logic             mosi,
	output logic             spi_read,
	output logic             spi_write,
	output logic             cmd_is_read,
	output logic             cmd_is_write,
	output spim_pkg::burst_t tx_addr,
	output spim_pkg::burst_t rx_addr,
	output spim_pkg::word_t  rx_wdata,
	output logic             stransvld_up
);

	spim_lane_if #(.WORD_W(WORD_W)) lane ();

	assign sclk = sclk_in;	// serial clock is the core clock

	spim_burst_ctrl #(
		.WORD_W  (WORD_W),
		.BURST_W (BURST_W)
	) spim_burst_ctrl_inst (
		.sclk_in      (sclk_in),
		.rst_n        (rst_n),
		.tx_rdata     (tx_rdata),
		.spim_brstlen (spim_brstlen),
		.s_transvld   (s_transvld),
		.spim_rdnwr   (spim_rdnwr),
		.spim_sselect (spim_sselect),
		.lane         (lane.ctrl),
		.ss_n_0       (ss_n_0),
		.ss_n_1       (ss_n_1),
		.ss_n_2       (ss_n_2),
		.ss_n_3       (ss_n_3),
		.spi_read     (spi_read),
		.spi_write    (spi_write),
		.cmd_is_read  (cmd_is_read),
		.cmd_is_write (cmd_is_write),
		.tx_addr      (tx_addr),
		.rx_addr      (rx_addr),
		.rx_wdata     (rx_wdata),
		.stransvld_up (stransvld_up)
	);

	// falling edge side
	spim_tx_shift #(.WORD_W(WORD_W)) spim_tx_shift_inst (
		.sclk_in (sclk_in),
		.rst_n   (rst_n),
		.lane    (lane.tx),
		.mosi    (mosi)
	);

	// rising edge side
	spim_rx_shift #(.WORD_W(WORD_W)) spim_rx_shift_inst (
		.sclk_in (sclk_in),
		.rst_n   (rst_n),
		.miso    (miso),
		.lane    (lane.rx)
	);

endmodule

/* tb/spim_slave_model.sv */
//////////////////////////////
// spi slave model, mode 0
// shifts out supplied miso words, collects mosi words
//////////////////////////////

module spim_slave_model (
	input  logic        sclk_in,
	input  logic [3:0]  ss_n,
	input  logic        mosi,
	input  logic [31:0] next_miso,	// word to send after the current one
	output logic        miso,
	output logic        miso_load,	// next_miso was taken
	output logic        word_done,
	output logic [1:0]  word_sel,
	output logic [31:0] mosi_word,
	output logic [31:0] miso_word
);

	logic [31:0] in_q;
	logic [31:0] out_q   = '0;
	logic [31:0] sent_q  = '0;	// whole word now on the way out
	logic [4:0]  bit_n   = '0;
	logic        shift_q = 1'b0;
	logic        bound_q = 1'b0;
	logic        loaded  = 1'b0;
	logic        sel_on;

	assign sel_on = ~&ss_n;
	assign miso   = out_q[31];

	initial begin
		word_done = 1'b0;
		miso_load = 1'b0;
	end

	always @(posedge sclk_in) begin
		word_done <= 1'b0;
		shift_q   <= sel_on;
		bound_q   <= sel_on & (bit_n == 5'd31);
		if (!sel_on)
			bit_n <= '0;
		else begin
			in_q  <= {in_q[30:0], mosi};
			bit_n <= bit_n + 1'b1;
			if (bit_n == 5'd31) begin
				word_done <= 1'b1;
				mosi_word <= {in_q[30:0], mosi};
				miso_word <= sent_q;
				word_sel  <= ss_n[0] ? (ss_n[1] ? (ss_n[2] ? 2'd3 : 2'd2) : 2'd1) : 2'd0;
			end
		end
	end

	// mode 0, the next bit goes out on the falling edge
	always @(negedge sclk_in) begin
		miso_load <= 1'b0;
		if (!loaded || bound_q) begin
			out_q     <= next_miso;
			sent_q    <= next_miso;
			loaded    <= 1'b1;
			miso_load <= 1'b1;
		end
		else if (shift_q)
			out_q <= {out_q[30:0], 1'b0};
	end

endmodule

/* tb/spim_tb.sv */
//////////////////////////////
// spim testbench
// runs a table of bursts and checks framing, data and strobes
//////////////////////////////

module spim_tb;

	import spim_pkg::*;

	localparam int N_BURSTS = 6;
	localparam int TIMEOUT  = 300;	// cycles from start to done

	// each row holds slave, read, length and a second start edge during the burst
	localparam logic [0:N_BURSTS-1][6:0] BURST_TAB = {
		{2'd0, 1'b0, 3'd1, 1'b0},
		{2'd1, 1'b1, 3'd2, 1'b0},
		{2'd2, 1'b0, 3'd3, 1'b1},
		{2'd3, 1'b1, 3'd4, 1'b1},
		{2'd2, 1'b1, 3'd1, 1'b0},
		{2'd1, 1'b0, 3'd4, 1'b0}
	};

	logic       sclk_in, rst_n, miso, s_transvld, spim_rdnwr;
	logic [1:0] spim_sselect;
	word_t      tx_rdata, rx_wdata;
	burst_t     spim_brstlen, tx_addr, rx_addr;
	logic       ss_n_0, ss_n_1, ss_n_2, ss_n_3, sclk, mosi;
	logic       spi_read, spi_write, cmd_is_read, cmd_is_write, stransvld_up;
	logic [3:0] ss_n;

	logic [15:0] lfsr_q;
	word_t       next_miso, mosi_word, miso_word;
	logic        miso_load, word_done;
	logic [1:0]  word_sel, exp_sel;
	logic        exp_rd;
	logic        hung      = 1'b0;
	int          errors    = 0;
	int          cur_burst = 0;
	int          rd_pulses, wr_pulses, done_pulses, slv_words;
	int          low_cnt [4];
	word_t       tx_tab [8];
	word_t       rx_got [8];
	word_t       mosi_got [8];
	word_t       miso_sent [8];

	assign ss_n = {ss_n_3, ss_n_2, ss_n_1, ss_n_0};

	spim_top spim_top_inst (.*);

	spim_slave_model slave_inst (
		.sclk_in   (sclk_in),
		.ss_n      (ss_n),
		.mosi      (mosi),
		.next_miso (next_miso),
		.miso      (miso),
		.miso_load (miso_load),
		.word_done (word_done),
		.word_sel  (word_sel),
		.mosi_word (mosi_word),
		.miso_word (miso_word)
	);

	initial begin
		sclk_in = 1'b0;
		forever #50 sclk_in = ~sclk_in;
	end

	// fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int i = 0; i < WORD_W; i++) begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			w      = {w[WORD_W-2:0], lfsr_q[0]};
		end
		return w;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// sclk is a copy of the core clock, sampled between edges
	always @(sclk_in) begin : sclk_check
		#10;
		compare_value("sclk", sclk_in, sclk);
	end

	//////////////////////////////
	// monitor and tx data supply
	//////////////////////////////
	always @(posedge sclk_in) begin : monitor
		string tag;
		tag = $sformatf("burst %0d", cur_burst);
		if (miso_load)
			next_miso <= rand_word();
		if (rst_n) begin
			for (int x = 0; x < 4; x++)
				if (!ss_n[x])
					low_cnt[x] = low_cnt[x] + 1;
			if (spi_read) begin
				compare_value({tag, " tx_addr"}, rd_pulses, tx_addr);
				tx_rdata  <= tx_tab[tx_addr];
				rd_pulses = rd_pulses + 1;
			end
			if (spi_write) begin
				compare_value({tag, " rx_addr"}, wr_pulses, rx_addr);
				rx_got[wr_pulses] = rx_wdata;
				wr_pulses         = wr_pulses + 1;
			end
			if (word_done) begin
				compare_value({tag, " selected slave"}, exp_sel, word_sel);
				mosi_got[slv_words]  = mosi_word;
				miso_sent[slv_words] = miso_word;
				slv_words            = slv_words + 1;
			end
			if (stransvld_up) begin
				compare_value({tag, " selects at done"}, 4'hf, ss_n);	// deselect comes first
				done_pulses = done_pulses + 1;
			end
			if (ss_n != 4'hf) begin
				compare_value({tag, " cmd_is_read"}, exp_rd, cmd_is_read);
				compare_value({tag, " cmd_is_write"}, !exp_rd, cmd_is_write);
			end
		end
	end

	task automatic wait_done();
		int          n;
		spim_state_e st;
		n = 0;
		while (!stransvld_up && n < TIMEOUT) begin
			@(posedge sclk_in);
			n++;
		end
		if (!stransvld_up) begin
			st = spim_top_inst.spim_burst_ctrl_inst.state;
			$display("burst %0d hung: no done pulse within %0d cycles, controller in %s",
				cur_burst, TIMEOUT, st.name());
			errors++;
			hung = 1'b1;
		end
	endtask

	task automatic check_burst(input logic [1:0] sel, input logic rd, input int len);
		string tag;
		tag = $sformatf("burst %0d", cur_burst);
		compare_value({tag, " done pulses"}, 1, done_pulses);
		compare_value({tag, " spi_read pulses"}, len, rd_pulses);
		compare_value({tag, " spi_write pulses"}, rd ? len : 0, wr_pulses);
		compare_value({tag, " slave words"}, len, slv_words);
		for (int x = 0; x < 4; x++)
			compare_value($sformatf("%s ss_n_%0d low edges", tag, x),
				(x == sel) ? WORD_W * len : 0, low_cnt[x]);
		for (int i = 0; i < len; i++) begin
			compare_value($sformatf("%s mosi word %0d", tag, i), tx_tab[i], mosi_got[i]);
			if (rd)
				compare_value($sformatf("%s rx_wdata %0d", tag, i), miso_sent[i], rx_got[i]);
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		logic [6:0] row;
		int         len;
		rst_n        = 1'b0;
		tx_rdata     = '0;
		spim_brstlen = '0;
		s_transvld   = 1'b0;
		spim_rdnwr   = 1'b0;
		spim_sselect = 2'd0;
		lfsr_q       = 16'd72;
		next_miso    = rand_word();
		repeat (2) @(posedge sclk_in);
		rst_n <= 1'b1;
		@(posedge sclk_in);
		compare_value("reset ss_n", 4'hf, ss_n);
		compare_value("reset mosi", 0, mosi);
		compare_value("reset strobes", 0, {spi_read, spi_write, stransvld_up});
		compare_value("reset cmd levels", 0, {cmd_is_read, cmd_is_write});
		compare_value("reset tx_addr", 0, tx_addr);
		compare_value("reset rx_addr", 0, rx_addr);

		for (int b = 0; b < N_BURSTS && !hung; b++) begin
			row         = BURST_TAB[b];
			len         = row[3:1];
			cur_burst   = b;
			exp_sel     = row[6:5];
			exp_rd      = row[4];
			rd_pulses   = 0;
			wr_pulses   = 0;
			done_pulses = 0;
			slv_words   = 0;
			for (int x = 0; x < 4; x++)
				low_cnt[x] = 0;
			for (int i = 0; i < len; i++)
				tx_tab[i] = rand_word();
			@(posedge sclk_in);
			spim_sselect <= row[6:5];
			spim_rdnwr   <= row[4];
			spim_brstlen <= burst_t'(len);
			s_transvld   <= 1'b1;
			@(posedge sclk_in);
			s_transvld <= 1'b0;
			if (row[0]) begin	// start edge while busy
				repeat (4) @(posedge sclk_in);
				s_transvld <= 1'b1;
				@(posedge sclk_in);
				s_transvld <= 1'b0;
			end
			wait_done();
			repeat (8) @(posedge sclk_in);	// a stray restart would fetch here
			check_burst(row[6:5], row[4], len);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* src.f */
rtl/spim_pkg.sv
rtl/spim_lane_if.sv
rtl/spim_tx_shift.sv
rtl/spim_rx_shift.sv
rtl/spim_burst_ctrl.sv
rtl/spim_top.sv
tb/spim_slave_model.sv
tb/spim_tb.sv

/* Bender.yml */
package:
  name: spim

sources:
  - rtl/spim_pkg.sv
  - rtl/spim_lane_if.sv
  - rtl/spim_tx_shift.sv
  - rtl/spim_rx_shift.sv
  - rtl/spim_burst_ctrl.sv
  - rtl/spim_top.sv
  - target: simulation
    files:
      - tb/spim_slave_model.sv
      - tb/spim_tb.sv
